//--- verilog/mul_cfg.svh
// Width and opcode definitions for the one-stage multiplier unit
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// Datapath widths
`define MUL_XLEN      32
`define MUL_TAG_BITS  3
`define MUL_LANE_BITS 8
`define MUL_OP_BITS   4

// Known opcodes
// Codes 10 to 15 are not decoded
`define MUL_OP_MUL    4'd0
`define MUL_OP_MULH   4'd1
`define MUL_OP_MULHU  4'd2
`define MUL_OP_MULHSU 4'd3
`define MUL_OP_CLMUL  4'd4
`define MUL_OP_CLMULH 4'd5
`define MUL_OP_CLMULR 4'd6
`define MUL_OP_SMUL8  4'd7
`define MUL_OP_UMUL8  4'd8
`define MUL_OP_SMAQA  4'd9

// Carry-less multiply modes
`define MUL_CLMUL_PLAIN 2'd0
`define MUL_CLMUL_REV   2'd1
`define MUL_CLMUL_HIGH  2'd2

`endif

//--- verilog/mul_pkg.sv
// Vector types shared by the multiplier unit and its testbench
`default_nettype none

`include "mul_cfg.svh"

package mul_pkg;

  // Operand or result word
  typedef logic [`MUL_XLEN-1:0] xlen_t;

  // Full width product
  typedef logic [2*`MUL_XLEN-1:0] dword_t;

  // Transaction identifier
  typedef logic [`MUL_TAG_BITS-1:0] tag_t;

  typedef logic [`MUL_OP_BITS-1:0] op_t;

  // Carry-less mode, plain or reversed or high
  typedef logic [1:0] clmul_mode_t;

endpackage

`default_nettype wire

//--- verilog/int_mult.sv
// Integer multiplier: one 33x33 signed product held in a register
`default_nettype none

`include "mul_cfg.svh"

module int_mult (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             load_i,
  input  logic             sign_a_i,
  input  logic             sign_b_i,
  input  mul_pkg::xlen_t   operand_a_i,
  input  mul_pkg::xlen_t   operand_b_i,
  output mul_pkg::dword_t  product_o
);
  import mul_pkg::*;

  logic [`MUL_XLEN:0]     a_ext;
  logic [`MUL_XLEN:0]     b_ext;
  logic [2*`MUL_XLEN+1:0] product_full;
  dword_t                 product_q;

  // Extra top bit turns unsigned operands into positive signed values
  assign a_ext = {operand_a_i[`MUL_XLEN-1] & sign_a_i, operand_a_i};
  assign b_ext = {operand_b_i[`MUL_XLEN-1] & sign_b_i, operand_b_i};

  assign product_full = $signed(a_ext) * $signed(b_ext);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      product_q <= '0;
    end else if (load_i) begin
      product_q <= product_full[2*`MUL_XLEN-1:0];
    end
  end

  assign product_o = product_q;

endmodule

`default_nettype wire

//--- verilog/clmul_unit.sv
// Carry-less multiplier with reversed and high modes, registered result
`default_nettype none

`include "mul_cfg.svh"

module clmul_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  load_i,
  input  mul_pkg::clmul_mode_t  mode_i,
  input  mul_pkg::xlen_t        operand_a_i,
  input  mul_pkg::xlen_t        operand_b_i,
  output mul_pkg::xlen_t        result_o
);
  import mul_pkg::*;

  logic  reverse;
  xlen_t a_rev;
  xlen_t b_rev;
  xlen_t a_sel;
  xlen_t b_sel;
  xlen_t acc;
  xlen_t acc_rev;
  xlen_t result_d;
  xlen_t result_q;

  assign reverse = (mode_i == `MUL_CLMUL_REV) || (mode_i == `MUL_CLMUL_HIGH);

  // Bit reversal of both operands and of the accumulated product
  always_comb begin
    for (int i = 0; i < `MUL_XLEN; i++) begin
      a_rev[i]   = operand_a_i[`MUL_XLEN-1-i];
      b_rev[i]   = operand_b_i[`MUL_XLEN-1-i];
      acc_rev[i] = acc[`MUL_XLEN-1-i];
    end
  end

  assign a_sel = reverse ? a_rev : operand_a_i;
  assign b_sel = reverse ? b_rev : operand_b_i;

  // ----------------------------------------
  // XOR accumulate of shifted copies of a
  // ----------------------------------------
  always_comb begin
    acc = '0;
    for (int i = 0; i < `MUL_XLEN; i++) begin
      if (b_sel[i]) begin
        acc = acc ^ (a_sel << i);
      end
    end
  end

  // Reversed mode yields bits 62..31, one more shift right gives 63..32
  always_comb begin
    case (mode_i)
      `MUL_CLMUL_REV:  result_d = acc_rev;
      `MUL_CLMUL_HIGH: result_d = acc_rev >> 1;
      default:         result_d = acc;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_q <= '0;
    end else if (load_i) begin
      result_q <= result_d;
    end
  end

  assign result_o = result_q;

endmodule

`default_nettype wire

//--- verilog/simd8_mult.sv
// Packed byte multiplier with four lanes and a dot product plus accumulate
`default_nettype none

`include "mul_cfg.svh"

module simd8_mult (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            load_i,
  input  logic            sign_a_i,
  input  logic            sign_b_i,
  input  mul_pkg::xlen_t  operand_a_i,
  input  mul_pkg::xlen_t  operand_b_i,
  input  mul_pkg::xlen_t  operand_c_i,
  output mul_pkg::xlen_t  lanes_o,
  output mul_pkg::xlen_t  dot_o
);
  import mul_pkg::*;

  localparam int unsigned num_lanes = `MUL_XLEN / `MUL_LANE_BITS;
  // Two 9-bit signed factors
  localparam int unsigned prod_bits = 2 * `MUL_LANE_BITS + 2;

  logic signed [prod_bits-1:0] prod [num_lanes];
  xlen_t                       prod_ext [num_lanes];
  xlen_t                       lanes_d;
  xlen_t                       dot_d;
  xlen_t                       lanes_q;
  xlen_t                       dot_q;

  // ----------------------------------------
  // Byte lanes
  // ----------------------------------------
  for (genvar l = 0; l < num_lanes; l++) begin : gen_lane
    logic [`MUL_LANE_BITS-1:0] a_byte;
    logic [`MUL_LANE_BITS-1:0] b_byte;

    assign a_byte = operand_a_i[l*`MUL_LANE_BITS +: `MUL_LANE_BITS];
    assign b_byte = operand_b_i[l*`MUL_LANE_BITS +: `MUL_LANE_BITS];

    assign prod[l] = $signed({a_byte[`MUL_LANE_BITS-1] & sign_a_i, a_byte}) *
                     $signed({b_byte[`MUL_LANE_BITS-1] & sign_b_i, b_byte});

    // Sign extension up to the word width for the sum
    assign prod_ext[l] = {{(`MUL_XLEN-prod_bits){prod[l][prod_bits-1]}}, prod[l]};
  end

  // Lane 1 in the upper half, lane 0 in the lower half
  assign lanes_d = {prod[1][2*`MUL_LANE_BITS-1:0], prod[0][2*`MUL_LANE_BITS-1:0]};

  // Dot product plus c, wraps at the word width
  always_comb begin
    dot_d = operand_c_i;
    for (int l = 0; l < num_lanes; l++) begin
      dot_d = dot_d + prod_ext[l];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lanes_q <= '0;
      dot_q   <= '0;
    end else if (load_i) begin
      lanes_q <= lanes_d;
      dot_q   <= dot_d;
    end
  end

  assign lanes_o = lanes_q;
  assign dot_o   = dot_q;

endmodule

`default_nettype wire

//--- verilog/mul_ctrl.sv
// Multiplier control: opcode decode, pipeline register and result select
`default_nettype none

`include "mul_cfg.svh"

module mul_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  input  mul_pkg::tag_t         tag_i,
  input  mul_pkg::op_t          op_i,
  input  mul_pkg::dword_t       int_result_i,
  input  mul_pkg::xlen_t        clmul_result_i,
  input  mul_pkg::xlen_t        simd_result_i,
  input  mul_pkg::xlen_t        dot_result_i,
  output logic                  load_o,
  output logic                  sign_a_o,
  output logic                  sign_b_o,
  output mul_pkg::clmul_mode_t  mode_o,
  output logic                  valid_o,
  output mul_pkg::tag_t         tag_o,
  output mul_pkg::xlen_t        result_o
);
  import mul_pkg::*;

  logic accept;
  logic valid_q;
  tag_t tag_q;
  op_t  op_q;

  // ----------------------------------------
  // Decode
  // ----------------------------------------

  // Unknown opcodes are filtered here and never reach the output
  assign accept = valid_i && (op_i inside {`MUL_OP_MUL, `MUL_OP_MULH, `MUL_OP_MULHU,
                                           `MUL_OP_MULHSU, `MUL_OP_CLMUL, `MUL_OP_CLMULH,
                                           `MUL_OP_CLMULR, `MUL_OP_SMUL8, `MUL_OP_UMUL8,
                                           `MUL_OP_SMAQA});
  assign load_o = accept;

  // Operand signedness per opcode
  always_comb begin
    sign_a_o = 1'b0;
    sign_b_o = 1'b0;
    if (op_i == `MUL_OP_MULH || op_i == `MUL_OP_SMUL8) begin
      sign_a_o = 1'b1;
      sign_b_o = 1'b1;
    end else if (op_i == `MUL_OP_SMAQA) begin
      // Unsigned a-bytes times signed b-bytes
      sign_b_o = 1'b1;
    end else if (op_i == `MUL_OP_MULHSU) begin
      sign_a_o = 1'b1;
    end
  end

  always_comb begin
    case (op_i)
      `MUL_OP_CLMULR: mode_o = `MUL_CLMUL_REV;
      `MUL_OP_CLMULH: mode_o = `MUL_CLMUL_HIGH;
      default:        mode_o = `MUL_CLMUL_PLAIN;
    endcase
  end

  // ----------------------------------------
  // Pipeline register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      tag_q   <= '0;
      op_q    <= `MUL_OP_MUL;
    end else begin
      valid_q <= accept;
      tag_q   <= tag_i;
      // Opcode only follows accepted ops so the result holds in idle cycles
      if (accept) begin
        op_q <= op_i;
      end
    end
  end

  assign valid_o = valid_q;
  assign tag_o   = tag_q;

  // Result select
  always_comb begin
    case (op_q)
      `MUL_OP_MULH, `MUL_OP_MULHU, `MUL_OP_MULHSU: begin
        result_o = int_result_i[2*`MUL_XLEN-1:`MUL_XLEN];
      end
      `MUL_OP_CLMUL, `MUL_OP_CLMULH, `MUL_OP_CLMULR: result_o = clmul_result_i;
      `MUL_OP_SMUL8, `MUL_OP_UMUL8:                   result_o = simd_result_i;
      `MUL_OP_SMAQA:                                  result_o = dot_result_i;
      default:                                        result_o = int_result_i[`MUL_XLEN-1:0];
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/mul_unit.sv
// Multiplier unit top: control block and the three datapaths
`default_nettype none

module mul_unit (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            valid_i,
  input  mul_pkg::tag_t   tag_i,
  input  mul_pkg::op_t    op_i,
  input  mul_pkg::xlen_t  operand_a_i,
  input  mul_pkg::xlen_t  operand_b_i,
  input  mul_pkg::xlen_t  operand_c_i,
  output logic            valid_o,
  output mul_pkg::tag_t   tag_o,
  output mul_pkg::xlen_t  result_o
);
  import mul_pkg::*;

  logic        load;
  logic        sign_a;
  logic        sign_b;
  clmul_mode_t mode;
  dword_t      int_product;
  xlen_t       clmul_result;
  xlen_t       simd_lanes;
  xlen_t       dot_sum;

  mul_ctrl i_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .valid_i        (valid_i),
    .tag_i          (tag_i),
    .op_i           (op_i),
    .int_result_i   (int_product),
    .clmul_result_i (clmul_result),
    .simd_result_i  (simd_lanes),
    .dot_result_i   (dot_sum),
    .load_o         (load),
    .sign_a_o       (sign_a),
    .sign_b_o       (sign_b),
    .mode_o         (mode),
    .valid_o        (valid_o),
    .tag_o          (tag_o),
    .result_o       (result_o)
  );

  // ----------------------------------------
  // Datapaths
  // ----------------------------------------
  int_mult i_int (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (load),
    .sign_a_i    (sign_a),
    .sign_b_i    (sign_b),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .product_o   (int_product)
  );

  clmul_unit i_clmul (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (load),
    .mode_i      (mode),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (clmul_result)
  );

  simd8_mult i_simd (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (load),
    .sign_a_i    (sign_a),
    .sign_b_i    (sign_b),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_c_i (operand_c_i),
    .lanes_o     (simd_lanes),
    .dot_o       (dot_sum)
  );

endmodule

`default_nettype wire

//--- tests/mul_unit_props.sv
// Timing assertions for the multiplier unit, bound into the top level
`default_nettype none

`include "mul_cfg.svh"

module mul_unit_props (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            in_valid_i,
  input mul_pkg::tag_t   in_tag_i,
  input mul_pkg::op_t    op_i,
  input logic            out_valid_i,
  input mul_pkg::tag_t   out_tag_i,
  input mul_pkg::xlen_t  result_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic        accept;
  // Number of failed assertions
  int unsigned fail_count;

  // Codes above SMAQA are unknown
  assign accept = in_valid_i && (op_i <= `MUL_OP_SMAQA);

  // Result and tag one cycle after an accepted op
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> out_valid_i && (out_tag_i == $past(in_tag_i)))
    else begin
      fail_count++;
      $error("valid_o or tag_o missing one cycle after an accepted op");
    end

  // Nothing comes out without an accepted op
  a_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !accept |=> !out_valid_i)
    else begin
      fail_count++;
      $error("valid_o high without an accepted op one cycle earlier");
    end

  a_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !out_valid_i && (out_tag_i == '0))
    else begin
      fail_count++;
      $error("valid_o or tag_o not cleared during reset");
    end

  a_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_i |-> !$isunknown(result_i))
    else begin
      fail_count++;
      $error("result_o unknown while valid_o is high");
    end

endmodule

`default_nettype wire

//--- tests/mul_unit_checker.sv
// Result checker: compares DUT outputs with the expected values of the data file
`default_nettype none

`include "mul_cfg.svh"

module mul_unit_checker (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            valid_i,
  input  mul_pkg::tag_t   tag_i,
  input  mul_pkg::xlen_t  result_i,
  output logic            done_o,
  output int              errors_o
);
  timeunit 1ns;
  timeprecision 100ps;

  import mul_pkg::*;

  localparam int result_timeout = 20;
  localparam int tail_cycles    = 8;

  function automatic string op_name(op_t op);
    case (op)
      `MUL_OP_MUL:    return "MUL";
      `MUL_OP_MULH:   return "MULH";
      `MUL_OP_MULHU:  return "MULHU";
      `MUL_OP_MULHSU: return "MULHSU";
      `MUL_OP_CLMUL:  return "CLMUL";
      `MUL_OP_CLMULH: return "CLMULH";
      `MUL_OP_CLMULR: return "CLMULR";
      `MUL_OP_SMUL8:  return "SMUL8";
      `MUL_OP_UMUL8:  return "UMUL8";
      `MUL_OP_SMAQA:  return "SMAQA";
      default:        return "unknown";
    endcase
  endfunction

  initial begin
    int    fd;
    int    rc;
    int    n;
    int    index;
    int    cycles;
    int    passed;
    int    failed;
    logic  got;
    logic  ok;
    logic  drop;
    string line;
    op_t   op;
    xlen_t a;
    xlen_t b;
    xlen_t c;
    xlen_t expected;
    tag_t  exp_tag;

    done_o   = 1'b0;
    errors_o = 0;
    index    = 0;
    passed   = 0;
    failed   = 0;
    fd = $fopen("tests/mul_unit_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      errors_o = 1;
    end else begin
      cycles = 0;
      while (rst_ni !== 1'b1 && cycles < 100) begin
        @(negedge clk_i);
        cycles++;
      end
      if (rst_ni !== 1'b1) begin
        $display("Reset was never released");
        errors_o++;
      end

      // ----------------------------------------
      // One data line per test
      // ----------------------------------------
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        n = (rc != 0) ? $sscanf(line, "%h %h %h %h %h %h", op, a, b, c, expected, drop) : 0;
        if (n == 6) begin
          exp_tag = tag_t'(index % (1 << `MUL_TAG_BITS));
          if (drop) begin
            // A stray result would show up as a tag error on the next test
            $display("Test %0d %s: dropped, no result expected", index, op_name(op));
            passed++;
          end else begin
            got    = 1'b0;
            cycles = 0;
            while (!got && cycles < result_timeout) begin
              @(negedge clk_i);
              if (valid_i) begin
                got = 1'b1;
              end else begin
                cycles++;
              end
            end
            ok = got;
            if (!got) begin
              $display("Test %0d %s: no result arrived within %0d cycles",
                       index, op_name(op), result_timeout);
            end else begin
              if (tag_i !== exp_tag) begin
                $display("Fail test %0d %s: tag_o got 0x%0h expected 0x%0h",
                         index, op_name(op), tag_i, exp_tag);
                ok = 1'b0;
              end
              if (result_i !== expected) begin
                $display("Fail test %0d %s: result_o got 0x%08h expected 0x%08h",
                         index, op_name(op), result_i, expected);
                ok = 1'b0;
              end
              if (ok) begin
                $display("Test %0d %s: ok, result_o 0x%08h", index, op_name(op), result_i);
              end
            end
            if (ok) begin
              passed++;
            end else begin
              failed++;
            end
          end
          index++;
        end
      end
      $fclose(fd);

      // No result may follow the last vector
      repeat (tail_cycles) begin
        @(negedge clk_i);
        if (valid_i) begin
          $display("Unexpected result with tag 0x%0h after the last test", tag_i);
          failed++;
        end
      end
      errors_o = errors_o + failed;
      $display("Tests run: %0d, passed: %0d, failed: %0d", index, passed, failed);
    end
    done_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/mul_unit_tb.sv
// Testbench for the multiplier unit: clock, reset and vector driving
`default_nettype none

`include "mul_cfg.svh"

module mul_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import mul_pkg::*;

  localparam int done_timeout = 500;

  logic   clk_i;
  logic   rst_ni;
  logic   valid_i;
  tag_t   tag_i;
  op_t    op_i;
  xlen_t  operand_a_i;
  xlen_t  operand_b_i;
  xlen_t  operand_c_i;
  logic   valid_o;
  tag_t   tag_o;
  xlen_t  result_o;
  logic   chk_done;
  int     chk_errors;
  integer seed;

  mul_unit i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_i     (valid_i),
    .tag_i       (tag_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_c_i (operand_c_i),
    .valid_o     (valid_o),
    .tag_o       (tag_o),
    .result_o    (result_o)
  );

  mul_unit_checker i_chk (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .valid_i  (valid_o),
    .tag_i    (tag_o),
    .result_i (result_o),
    .done_o   (chk_done),
    .errors_o (chk_errors)
  );

  bind mul_unit mul_unit_props i_props (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (valid_i),
    .in_tag_i    (tag_i),
    .op_i        (op_i),
    .out_valid_i (valid_o),
    .out_tag_i   (tag_o),
    .result_i    (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Driving, 10 ns after the rising edge
  // ----------------------------------------
  task automatic drive_vector(input op_t op, input xlen_t a, input xlen_t b,
                              input xlen_t c, input tag_t tag);
    @(posedge clk_i);
    #10;
    valid_i     = 1'b1;
    op_i        = op;
    tag_i       = tag;
    operand_a_i = a;
    operand_b_i = b;
    operand_c_i = c;
  endtask

  task automatic drive_idle();
    @(posedge clk_i);
    #10;
    valid_i = 1'b0;
  endtask

  initial begin
    int          fd;
    int          rc;
    int          n;
    int          index;
    int          cycles;
    logic        file_ok;
    logic [31:0] r;
    string       line;
    op_t         op;
    xlen_t       a;
    xlen_t       b;
    xlen_t       c;
    xlen_t       expected;
    logic        drop;

    rst_ni      = 1'b0;
    valid_i     = 1'b0;
    tag_i       = '0;
    op_i        = '0;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    seed        = 32'h44520426;
    index       = 0;
    repeat (16) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    fd = $fopen("tests/mul_unit_testdata.txt", "r");
    file_ok = (fd != 0);
    if (!file_ok) begin
      $display("Could not open the test data file for driving");
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        n = (rc != 0) ? $sscanf(line, "%h %h %h %h %h %h", op, a, b, c, expected, drop) : 0;
        if (n == 6) begin
          drive_vector(op, a, b, c, tag_t'(index % (1 << `MUL_TAG_BITS)));
          index++;
          // Some vectors go back to back, others get a short gap
          r = $random(seed);
          if (r[2]) begin
            repeat (r[1:0]) drive_idle();
          end
        end
      end
      $fclose(fd);
    end
    drive_idle();

    cycles = 0;
    while (!chk_done && cycles < done_timeout) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!chk_done) begin
      $display("Checker did not finish within %0d cycles", done_timeout);
    end
    if (chk_done && file_ok && chk_errors == 0 && i_dut.i_props.fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
verilog/mul_pkg.sv
verilog/int_mult.sv
verilog/clmul_unit.sv
verilog/simd8_mult.sv
verilog/mul_ctrl.sv
verilog/mul_unit.sv
tests/mul_unit_props.sv
tests/mul_unit_checker.sv
tests/mul_unit_tb.sv

//--- tests/mul_unit_testdata.txt
// Columns: op a b c expected drop, all in hex
// drop 1 marks an unknown opcode that must not produce a result
0 FFFFFFFE 00000003 00000000 FFFFFFFA 0
1 FFFFFFFE 00000003 00000000 FFFFFFFF 0
2 FFFFFFFE 00000003 00000000 00000002 0
3 FFFFFFFE 00000003 00000000 FFFFFFFF 0
0 80000000 FFFFFFFF 00000000 80000000 0
1 80000000 FFFFFFFF 00000000 00000000 0
2 80000000 FFFFFFFF 00000000 7FFFFFFF 0
3 80000000 FFFFFFFF 00000000 80000000 0
1 7FFFFFFF 7FFFFFFF 00000000 3FFFFFFF 0
A 12345678 9ABCDEF0 00000000 00000000 1
4 80000001 80000003 00000000 00000003 0
5 80000001 80000003 00000000 40000001 0
6 80000001 80000003 00000000 80000002 0
5 FFFFFFFF FFFFFFFF 00000000 55555555 0
6 FFFFFFFF FFFFFFFF 00000000 AAAAAAAA 0
7 000080FF 000003FE 00000000 FE800002 0
8 000080FF 000003FE 00000000 0180FD02 0
7 00007F80 00008080 00000000 C0804000 0
8 00007F80 00008080 00000000 3F804000 0
9 01020304 FF020304 00000100 0000011C 0
9 FFFFFFFF 7F7F7F7F FFFFFFF0 0001F9F4 0
9 80808080 80808080 00000010 FFFF0010 0
F 00000001 00000001 00000000 00000000 1
